// File: src/eg_cfg_pkg.sv
package eg_cfg_pkg;

    ////////////////////////////////////////
    // round and field sizes
    ////////////////////////////////////////
    localparam int SLOTS = 18;       // operator slots per round
    localparam int ATT_W = 10;       // attenuation, 0 loudest
    localparam int RATE_W = 6;       // effective rate
    localparam int CNT_W = 15;       // global envelope counter
    localparam int TL_W = 6;         // total level

    localparam logic [ATT_W-1:0] ATT_MAX = 10'h3ff;  // silent

    ////////////////////////////////////////
    // rate constants
    ////////////////////////////////////////
    localparam logic [RATE_W-1:0] RATE_MAX = 6'd63;

    // slowest pacing spans this many counter bits
    localparam logic [3:0] STEP_TOP = 4'd13;

    // attack rate that jumps straight to full volume
    localparam logic [3:0] AR_INSTANT = 4'd15;

    localparam int SL_SHIFT = 5;     // sustain level x32

endpackage

// File: src/eg_phase_pkg.sv
package eg_phase_pkg;

    ////////////////////////////////////////
    // envelope phases
    ////////////////////////////////////////

    // encoding is stored as-is in the phase ring
    typedef enum logic [1:0] {
        ATTACK  = 2'd0,
        DECAY   = 2'd1,
        SUSTAIN = 2'd2,
        RELEASE = 2'd3
    } eg_phase_t;

    // every slot starts out released, i.e. silent
    localparam eg_phase_t PHASE_RST = RELEASE;

endpackage

// File: src/eg_slot_ring.sv
`timescale 1ns/1ps

module eg_slot_ring #(
    parameter int WIDTH = 1,
    parameter int STAGES = 18,
    parameter logic [WIDTH-1:0] RST_VAL = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] sr [STAGES];

    // one slot per cell, shifts once per slot tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < STAGES; i++) begin
                sr[i] <= RST_VAL;
            end
        end else if (cen) begin
            sr[0] <= din;
            for (int i = 1; i < STAGES; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

    assign dout = sr[STAGES-1];  // value written STAGES ticks ago

endmodule

// File: src/eg_counter.sv
`timescale 1ns/1ps

module eg_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cen,
    input  logic                        zero,
    input  logic                        eg_stop,
    output logic [eg_cfg_pkg::CNT_W-1:0] eg_cnt,
    output logic [eg_cfg_pkg::CNT_W-1:0] eg_carry
);

    logic [eg_cfg_pkg::CNT_W-1:0] cnt_inc;

    assign cnt_inc = eg_cnt + 1'b1;

    // advances once per round, at slot 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eg_cnt   <= '0;
            eg_carry <= '0;
        end else if (cen && zero) begin
            if (!eg_stop) begin
                eg_cnt   <= cnt_inc;
                eg_carry <= eg_cnt ^ cnt_inc;  // toggled bits
            end else begin
                // no toggles, so no step fires this round
                eg_carry <= '0;
            end
        end
    end

endmodule

// File: src/eg_phase_decode.sv
`timescale 1ns/1ps

module eg_phase_decode (
    input  logic                          keyon,
    input  logic                          keyon_last,
    input  eg_phase_pkg::eg_phase_t       phase_in,
    input  logic [eg_cfg_pkg::ATT_W-1:0]  att_in,
    input  logic                          en_sus,
    input  logic [3:0]                    arate,
    input  logic [3:0]                    drate,
    input  logic [3:0]                    rrate,
    input  logic [3:0]                    sl,
    output eg_phase_pkg::eg_phase_t       phase_next,
    output logic [3:0]                    base_rate,
    output logic                          pg_rst
);

    logic                         keyon_now;
    logic                         keyoff_now;
    logic [eg_cfg_pkg::ATT_W-1:0] sus_lvl;

    ////////////////////////////////////////
    // key edges
    ////////////////////////////////////////
    assign keyon_now  = keyon & ~keyon_last;
    assign keyoff_now = ~keyon & keyon_last;
    assign pg_rst     = keyon_now;  // phase restarts with the attack

    assign sus_lvl = {{(eg_cfg_pkg::ATT_W-4){1'b0}}, sl} << eg_cfg_pkg::SL_SHIFT;

    ////////////////////////////////////////
    // phase transition
    ////////////////////////////////////////
    always_comb begin
        phase_next = phase_in;
        if (keyon_now) begin
            phase_next = eg_phase_pkg::ATTACK;
        end else if (keyoff_now) begin
            phase_next = eg_phase_pkg::RELEASE;
        end else begin
            case (phase_in)
                eg_phase_pkg::ATTACK: begin
                    if (att_in == '0) phase_next = eg_phase_pkg::DECAY;
                end
                eg_phase_pkg::DECAY: begin
                    // sustain level reached
                    if (att_in >= sus_lvl) phase_next = eg_phase_pkg::SUSTAIN;
                end
                default: begin
                    phase_next = phase_in;  // sustain and release hold
                end
            endcase
        end
    end

    // rate follows the phase the slot is entering
    always_comb begin
        case (phase_next)
            eg_phase_pkg::ATTACK:  base_rate = arate;
            eg_phase_pkg::DECAY:   base_rate = drate;
            eg_phase_pkg::SUSTAIN: base_rate = en_sus ? 4'd0 : rrate;
            default:               base_rate = rrate;
        endcase
    end

endmodule

// File: src/eg_step.sv
`timescale 1ns/1ps

module eg_step (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cen,
    input  eg_phase_pkg::eg_phase_t       phase,
    input  logic [3:0]                    base_rate,
    input  logic [3:0]                    keycode,
    input  logic                          ksr,
    input  logic [eg_cfg_pkg::ATT_W-1:0]  att_in,
    input  logic [eg_cfg_pkg::CNT_W-1:0]  eg_cnt,
    input  logic [eg_cfg_pkg::CNT_W-1:0]  eg_carry,
    output logic [eg_cfg_pkg::ATT_W-1:0]  att_next
);

    logic [6:0]                    rate_sum;
    logic [eg_cfg_pkg::RATE_W-1:0] rate;
    logic [3:0]                    shift;
    logic [eg_cfg_pkg::CNT_W-1:0]  mask;
    logic                          step;
    logic [eg_cfg_pkg::ATT_W-1:0]  att_calc;

    ////////////////////////////////////////
    // effective rate
    ////////////////////////////////////////
    assign rate_sum = {1'b0, base_rate, 2'b00}
                    + (ksr ? {3'b000, keycode} : {5'b00000, keycode[3:2]});

    always_comb begin
        if (rate_sum > {1'b0, eg_cfg_pkg::RATE_MAX}) begin
            rate = eg_cfg_pkg::RATE_MAX;  // cap
        end else begin
            rate = rate_sum[eg_cfg_pkg::RATE_W-1:0];
        end
    end

    ////////////////////////////////////////
    // step decision
    ////////////////////////////////////////
    always_comb begin
        if (rate[eg_cfg_pkg::RATE_W-1:2] >= eg_cfg_pkg::STEP_TOP) begin
            shift = 4'd0;  // every round
        end else begin
            shift = eg_cfg_pkg::STEP_TOP - rate[eg_cfg_pkg::RATE_W-1:2];
        end
        mask = ~({eg_cfg_pkg::CNT_W{1'b1}} << shift);
        // carry into bit shift means the counter just crossed the boundary
        step = (base_rate != 4'd0) && ((eg_cnt & mask) == '0) && eg_carry[shift];
    end

    // attack subtracts, everything else counts up
    always_comb begin
        att_calc = att_in;
        if (phase == eg_phase_pkg::ATTACK) begin
            if (base_rate == eg_cfg_pkg::AR_INSTANT) begin
                att_calc = '0;
            end else if (step && att_in != '0) begin
                att_calc = att_in - (att_in >> 4) - 1'b1;
            end
        end else if (step && att_in != eg_cfg_pkg::ATT_MAX) begin
            att_calc = att_in + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            att_next <= eg_cfg_pkg::ATT_MAX;
        end else if (cen) begin
            att_next <= att_calc;
        end
    end

endmodule

// File: src/eg_level_out.sv
`timescale 1ns/1ps

module eg_level_out (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cen,
    input  logic [eg_cfg_pkg::ATT_W-1:0]  att,
    input  logic [eg_cfg_pkg::TL_W-1:0]   tl,
    input  logic [1:0]                    ksl,
    input  logic [3:0]                    fnum_hi,
    input  logic [2:0]                    block,
    input  logic [3:0]                    lfo_mod,
    input  logic                          amsen,
    input  logic                          ams,
    output logic [eg_cfg_pkg::ATT_W-1:0]  eg_v
);

    logic [6:0]                   ks_base;
    logic [8:0]                   ks_term;
    logic [4:0]                   mod_term;
    logic [eg_cfg_pkg::ATT_W+1:0] sum;  // headroom before the clamp

    assign ks_base  = {1'b0, block, 3'b000} + {3'b000, fnum_hi};
    assign ks_term  = (ksl == 2'd0) ? 9'd0 : {2'b00, ks_base} << (ksl - 2'd1);
    assign mod_term = amsen ? (ams ? {lfo_mod, 1'b0} : {1'b0, lfo_mod}) : 5'd0;

    assign sum = {2'b00, att}
               + {{(eg_cfg_pkg::ATT_W-eg_cfg_pkg::TL_W){1'b0}}, tl, 2'b00}
               + {3'b000, ks_term}
               + {7'b0000000, mod_term};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eg_v <= eg_cfg_pkg::ATT_MAX;
        end else if (cen) begin
            if (sum > {2'b00, eg_cfg_pkg::ATT_MAX}) begin
                eg_v <= eg_cfg_pkg::ATT_MAX;  // clamp to silent
            end else begin
                eg_v <= sum[eg_cfg_pkg::ATT_W-1:0];
            end
        end
    end

endmodule

// File: src/eg_top.sv
`timescale 1ns/1ps

module eg_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cen,
    input  logic                          zero,
    input  logic                          eg_stop,
    input  logic                          keyon,
    input  logic                          en_sus,
    input  logic [3:0]                    arate,
    input  logic [3:0]                    drate,
    input  logic [3:0]                    rrate,
    input  logic [3:0]                    sl,
    input  logic                          ksr,
    input  logic [3:0]                    keycode,
    input  logic [3:0]                    fnum_hi,
    input  logic [2:0]                    block,
    input  logic [eg_cfg_pkg::TL_W-1:0]   tl,
    input  logic [1:0]                    ksl,
    input  logic                          amsen,
    input  logic                          ams,
    input  logic [3:0]                    lfo_mod,
    output logic [eg_cfg_pkg::ATT_W-1:0]  eg_v,
    output logic                          pg_rst
);

    logic [eg_cfg_pkg::CNT_W-1:0] eg_cnt;
    logic [eg_cfg_pkg::CNT_W-1:0] eg_carry;

    // stage I
    logic                          keyon_last;
    logic [1:0]                    phase_q;
    eg_phase_pkg::eg_phase_t       phase_in;
    eg_phase_pkg::eg_phase_t       phase_next;
    logic [eg_cfg_pkg::ATT_W-1:0]  att_i;
    logic [3:0]                    base_rate_i;
    logic                          pg_rst_i;

    // stage II
    eg_phase_pkg::eg_phase_t       phase_ii;
    logic [3:0]                    base_rate_ii;
    logic [eg_cfg_pkg::ATT_W-1:0]  att_ii;
    logic [3:0]                    keycode_ii;
    logic                          ksr_ii;
    logic [eg_cfg_pkg::TL_W-1:0]   tl_ii, tl_iii;
    logic [1:0]                    ksl_ii, ksl_iii;
    logic [3:0]                    fnum_hi_ii, fnum_hi_iii;
    logic [2:0]                    block_ii, block_iii;
    logic [3:0]                    lfo_mod_ii, lfo_mod_iii;
    logic                          amsen_ii, amsen_iii;
    logic                          ams_ii, ams_iii;

    // stage III
    logic [eg_cfg_pkg::ATT_W-1:0]  att_iii;

    eg_counter u_cnt (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen      ( cen      ),
        .zero     ( zero     ),
        .eg_stop  ( eg_stop  ),
        .eg_cnt   ( eg_cnt   ),
        .eg_carry ( eg_carry )
    );

    ////////////////////////////////////////
    // per-slot state rings
    ////////////////////////////////////////
    eg_slot_ring #(
        .WIDTH   ( 2                       ),
        .STAGES  ( eg_cfg_pkg::SLOTS       ),
        .RST_VAL ( eg_phase_pkg::PHASE_RST )
    ) u_phase_ring (
        .clk   ( clk        ),
        .rst_n ( rst_n      ),
        .cen   ( cen        ),
        .din   ( phase_next ),
        .dout  ( phase_q    )
    );

    assign phase_in = eg_phase_pkg::eg_phase_t'(phase_q);

    // written two ticks late, from the execute stage
    eg_slot_ring #(
        .WIDTH   ( eg_cfg_pkg::ATT_W   ),
        .STAGES  ( eg_cfg_pkg::SLOTS-2 ),
        .RST_VAL ( eg_cfg_pkg::ATT_MAX )
    ) u_att_ring (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .cen   ( cen     ),
        .din   ( att_iii ),
        .dout  ( att_i   )
    );

    eg_slot_ring #(
        .WIDTH   ( 1                 ),
        .STAGES  ( eg_cfg_pkg::SLOTS ),
        .RST_VAL ( 1'b0              )
    ) u_key_ring (
        .clk   ( clk        ),
        .rst_n ( rst_n      ),
        .cen   ( cen        ),
        .din   ( keyon      ),
        .dout  ( keyon_last )
    );

    ////////////////////////////////////////
    // stage I, decode
    ////////////////////////////////////////
    eg_phase_decode u_decode (
        .keyon      ( keyon       ),
        .keyon_last ( keyon_last  ),
        .phase_in   ( phase_in    ),
        .att_in     ( att_i       ),
        .en_sus     ( en_sus      ),
        .arate      ( arate       ),
        .drate      ( drate       ),
        .rrate      ( rrate       ),
        .sl         ( sl          ),
        .phase_next ( phase_next  ),
        .base_rate  ( base_rate_i ),
        .pg_rst     ( pg_rst_i    )
    );

    // stage II and III pipeline, late inputs ride along
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pg_rst       <= 1'b0;
            phase_ii     <= eg_phase_pkg::PHASE_RST;
            base_rate_ii <= 4'd0;
            att_ii       <= eg_cfg_pkg::ATT_MAX;
            keycode_ii   <= 4'd0;
            ksr_ii       <= 1'b0;
            {tl_ii, ksl_ii, fnum_hi_ii, block_ii}      <= '0;
            {lfo_mod_ii, amsen_ii, ams_ii}             <= '0;
            {tl_iii, ksl_iii, fnum_hi_iii, block_iii}  <= '0;
            {lfo_mod_iii, amsen_iii, ams_iii}          <= '0;
        end else if (cen) begin
            pg_rst       <= pg_rst_i;
            phase_ii     <= phase_next;
            base_rate_ii <= base_rate_i;
            att_ii       <= att_i;
            keycode_ii   <= keycode;
            ksr_ii       <= ksr;
            {tl_ii, ksl_ii, fnum_hi_ii, block_ii}      <= {tl, ksl, fnum_hi, block};
            {lfo_mod_ii, amsen_ii, ams_ii}             <= {lfo_mod, amsen, ams};
            {tl_iii, ksl_iii, fnum_hi_iii, block_iii}  <= {tl_ii, ksl_ii, fnum_hi_ii, block_ii};
            {lfo_mod_iii, amsen_iii, ams_iii}          <= {lfo_mod_ii, amsen_ii, ams_ii};
        end
    end

    ////////////////////////////////////////
    // stage II, execute
    ////////////////////////////////////////
    eg_step u_step (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .cen       ( cen          ),
        .phase     ( phase_ii     ),
        .base_rate ( base_rate_ii ),
        .keycode   ( keycode_ii   ),
        .ksr       ( ksr_ii       ),
        .att_in    ( att_ii       ),
        .eg_cnt    ( eg_cnt       ),
        .eg_carry  ( eg_carry     ),
        .att_next  ( att_iii      )
    );

    // stage III, output level
    eg_level_out u_level (
        .clk     ( clk         ),
        .rst_n   ( rst_n       ),
        .cen     ( cen         ),
        .att     ( att_iii     ),
        .tl      ( tl_iii      ),
        .ksl     ( ksl_iii     ),
        .fnum_hi ( fnum_hi_iii ),
        .block   ( block_iii   ),
        .lfo_mod ( lfo_mod_iii ),
        .amsen   ( amsen_iii   ),
        .ams     ( ams_iii     ),
        .eg_v    ( eg_v        )
    );

endmodule

// File: tb/eg_top_props.sv
`timescale 1ns/1ps

module eg_top_props (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         cen,
    input logic [eg_cfg_pkg::ATT_W-1:0] att,
    input logic [eg_cfg_pkg::ATT_W-1:0] eg_v,
    input logic                         pg_rst
);

    // a slot comes round again SLOTS ticks later
    pg_rst_single : assert property (@(posedge clk) disable iff (!rst_n)
        (cen && pg_rst) |-> ##(eg_cfg_pkg::SLOTS) !pg_rst)
        else $error("pg_rst high on two visits of the same slot");

    // extra terms and the clamp never make a slot louder
    eg_v_floor : assert property (@(posedge clk) disable iff (!rst_n)
        cen |=> eg_v >= $past(att))
        else $error("eg_v below the attenuation it was built from");

    reset_outputs : assert property (@(posedge clk)
        !rst_n |=> (eg_v == eg_cfg_pkg::ATT_MAX && !pg_rst))
        else $error("outputs not at reset values during reset");

endmodule

bind eg_top eg_top_props eg_top_props_inst (
    .clk    ( clk     ),
    .rst_n  ( rst_n   ),
    .cen    ( cen     ),
    .att    ( att_iii ),
    .eg_v   ( eg_v    ),
    .pg_rst ( pg_rst  )
);

// File: tb/eg_checker.sv
`timescale 1ns/1ps

module eg_checker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [eg_cfg_pkg::ATT_W-1:0] eg_v,
    input  logic                         pg_rst,
    input  logic [eg_cfg_pkg::ATT_W-1:0] exp_eg,
    input  logic                         exp_pg,
    input  logic                         exp_valid,
    output int                           err_cnt,
    output int                           check_cnt
);

    // pg_rst is due one tick later, eg_v three ticks later
    logic                         pg_exp_d;
    logic                         pg_vld_d;
    logic [eg_cfg_pkg::ATT_W-1:0] eg_exp_d [3];
    logic [2:0]                   eg_vld_d;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pg_exp_d <= 1'b0;
            pg_vld_d <= 1'b0;
            eg_vld_d <= '0;
            for (int i = 0; i < 3; i++) begin
                eg_exp_d[i] <= '0;
            end
        end else begin
            pg_exp_d    <= exp_pg;
            pg_vld_d    <= exp_valid;
            eg_exp_d[0] <= exp_eg;
            eg_exp_d[1] <= eg_exp_d[0];
            eg_exp_d[2] <= eg_exp_d[1];
            eg_vld_d    <= {eg_vld_d[1:0], exp_valid};
        end
    end

    initial begin
        err_cnt   = 0;
        check_cnt = 0;
    end

    // compare mid-cycle, outputs settled
    always @(negedge clk) begin
        if (pg_vld_d) begin
            check_cnt++;
            if (pg_rst !== pg_exp_d) begin
                $display("Mismatch pg_rst: got %h, expected %h", pg_rst, pg_exp_d);
                err_cnt++;
            end
        end
        if (eg_vld_d[2]) begin
            check_cnt++;
            if (eg_v !== eg_exp_d[2]) begin
                $display("Mismatch eg_v: got %h, expected %h", eg_v, eg_exp_d[2]);
                err_cnt++;
            end
        end
    end

endmodule

// File: tb/eg_top_tb.sv
`timescale 1ns/1ps

module eg_top_tb;

    localparam int  CLK_PERIOD = 40;
    localparam int  DRIVE_DLY  = 2;     // input skew after the rising edge
    localparam int  RST_CYCLES = 8;
    localparam int  DRAIN      = 5;     // ticks to flush the pipeline
    localparam string STIM_FILE = "tb/eg_stim.txt";

    logic                         clk;
    logic                         rst_n;
    logic                         cen;
    logic                         zero;
    logic                         eg_stop;
    logic                         keyon;
    logic                         en_sus;
    logic [3:0]                   arate;
    logic [3:0]                   drate;
    logic [3:0]                   rrate;
    logic [3:0]                   sl;
    logic                         ksr;
    logic [3:0]                   keycode;
    logic [3:0]                   fnum_hi;
    logic [2:0]                   block;
    logic [eg_cfg_pkg::TL_W-1:0]  tl;
    logic [1:0]                   ksl;
    logic                         amsen;
    logic                         ams;
    logic [3:0]                   lfo_mod;
    logic [eg_cfg_pkg::ATT_W-1:0] eg_v;
    logic                         pg_rst;

    // expected values travel to the checker with a valid flag
    logic [eg_cfg_pkg::ATT_W-1:0] exp_eg;
    logic                         exp_pg;
    logic                         exp_valid;
    int                           err_cnt;
    int                           check_cnt;

    string stim_q[$];
    logic  stim_loaded;

    eg_top eg_top_inst (.*);

    eg_checker u_checker (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .eg_v      ( eg_v      ),
        .pg_rst    ( pg_rst    ),
        .exp_eg    ( exp_eg    ),
        .exp_pg    ( exp_pg    ),
        .exp_valid ( exp_valid ),
        .err_cnt   ( err_cnt   ),
        .check_cnt ( check_cnt )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    ////////////////////////////////////////
    // stim file handling
    ////////////////////////////////////////
    task automatic load_stim();
        int    fd;
        string line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") stim_q.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_line(input string line);
        int n;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    zero, keyon, en_sus, arate, drate, rrate, sl, ksr, keycode,
                    fnum_hi, block, tl, ksl, amsen, ams, lfo_mod, eg_stop,
                    exp_eg, exp_pg);
        exp_valid = (n == 19);
        if (n != 19) $display("stimulus line could not be parsed: %s", line);
    endtask

    task automatic drive_idle();
        {zero, eg_stop, keyon, en_sus, ksr, amsen, ams} = '0;
        {arate, drate, rrate, sl, keycode, fnum_hi, lfo_mod} = '0;
        block     = '0;
        tl        = '0;
        ksl       = '0;
        exp_eg    = eg_cfg_pkg::ATT_MAX;
        exp_pg    = 1'b0;
        exp_valid = 1'b0;
    endtask

    // watchdog, sized from the stimulus length
    initial begin
        wait (stim_loaded === 1'b1);
        #(CLK_PERIOD * (stim_q.size() + 20));
        $display("timeout: the run did not finish in the expected time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        stim_loaded = 1'b0;
        rst_n       = 1'b0;
        cen         = 1'b1;  // one slot per clock
        drive_idle();
        load_stim();
        stim_loaded = 1'b1;

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        foreach (stim_q[i]) begin
            if (i > 0) begin
                @(posedge clk);
                #DRIVE_DLY;
            end
            apply_line(stim_q[i]);
        end
        @(posedge clk);
        #DRIVE_DLY;
        drive_idle();
        repeat (DRAIN) @(posedge clk);
        #DRIVE_DLY;

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0 && stim_q.size() > 0 && check_cnt == 2 * stim_q.size()) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb/eg_stim.txt
# one line per tick, all hex: zero keyon en_sus arate drate rrate sl ksr keycode
# fnum_hi block tl ksl amsen ams lfo_mod eg_stop exp_eg_v exp_pg_rst
1 1 1 f f 0 1 0 0 0 0 00 0 0 0 0 0 000 1
0 1 0 d 0 0 0 0 0 0 0 00 0 0 0 0 0 3bf 1
0 1 0 c 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 1
0 1 0 f 0 f 0 0 0 0 0 00 0 0 0 0 0 000 1
0 0 0 0 0 0 0 0 0 f 7 3f 3 1 1 f 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
1 1 1 f f 0 1 0 0 2 1 02 1 1 1 3 0 019 0
0 1 0 d 0 0 0 0 0 0 0 00 0 0 0 0 0 383 0
0 1 0 c 0 0 0 0 0 0 0 00 0 0 0 0 0 3bf 0
0 0 0 f 0 f 0 0 0 f 7 00 3 0 0 0 0 11d 0
0 1 0 f 0 0 0 0 0 f 7 3f 3 1 1 f 0 236 1
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 3ff 0
1 1 1 f f 0 1 0 0 0 0 01 0 0 0 0 1 005 0
0 1 0 d 0 0 0 0 0 0 0 00 0 0 0 0 1 383 0
0 1 0 c 0 0 0 0 0 0 0 00 0 0 0 0 1 3bf 0

// File: eg_top.f
src/eg_cfg_pkg.sv
src/eg_phase_pkg.sv
src/eg_slot_ring.sv
src/eg_counter.sv
src/eg_phase_decode.sv
src/eg_step.sv
src/eg_level_out.sv
src/eg_top.sv
tb/eg_top_props.sv
tb/eg_checker.sv
tb/eg_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the envelope generator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module eg_top_tb \
    -f eg_top.f -o eg_sim > build.log 2>&1 \
    && ./obj_dir/eg_sim > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "SOME TESTS FAILED" sim.log \
    && grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { cat build.log sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
